/* tb.f */
+incdir+hw
+incdir+dv
hw/x86_opnd_pkg.sv
hw/opnd_fields_if.sv
hw/mem_hint_if.sv
hw/opnd_fields.sv
hw/mem_opnd_fetch.sv
hw/decode_opnds.sv
hw/opnd_decode_stage.sv
dv/clk_gen.sv
dv/opnd_decode_tb.sv

/* dv/opnd_vectors.svh */
`ifndef OPND_VECTORS_SVH
`define OPND_VECTORS_SVH

// Columns: instr, cmd, form, flags {imm1,sext,one0,one1,one2,w0,w1},
// hint1 {wr,addr,data}, hint2 {wr,addr,data}, len, opnd0..2, dest0 kind/sel, dest1 kind/sel
// Registers fixed: eax 100 ecx 10 edx 20 ebx 1000 esp 8000 ebp 2000 esi 3000 edi 4000
task automatic load_vectors();
  // Register forms
  add_vec(88'hCB01, CMD_OTHER, OPND_ENC_MODREGRM_RM_REG, 7'b0000010, 0, 0, 0, 0, 0, 0,
          1, 32'h1000, 32'h10, 0, DEST_REG, 3, DEST_NONE, 0);
  add_vec(88'hD003, CMD_OTHER, OPND_ENC_MODREGRM_REG_RM, 7'b0000010, 0, 0, 0, 0, 0, 0,
          1, 32'h20, 32'h100, 0, DEST_REG, 2, DEST_NONE, 0);
  add_vec(88'h46, CMD_OTHER, OPND_ENC_REG, 7'b0001110, 0, 0, 0, 0, 0, 0,
          0, 32'h3000, 1, 1, DEST_REG, 6, DEST_NONE, 0);
  add_vec(88'h97, CMD_OTHER, OPND_ENC_EAX_REG, 7'b0000011, 0, 0, 0, 0, 0, 0,
          0, 32'h100, 32'h4000, 0, DEST_REG, 0, DEST_REG, 7);
  add_vec(88'h12345678_05, CMD_OTHER, OPND_ENC_EAX_IMM, 7'b0000010, 0, 0, 0, 0, 0, 0,
          4, 32'h100, 32'h12345678, 0, DEST_REG, 0, DEST_NONE, 0);
  // Memory operands and hint lookup
  add_vec(88'h08_8B_44_8B, CMD_OTHER, OPND_ENC_MODREGRM_REG_RM, 7'b0000010,
          0, 32'h1048, 32'hCAFE0001, 0, 0, 0,
          3, 32'h100, 32'hCAFE0001, 0, DEST_REG, 0, DEST_NONE, 0);
  add_vec(88'h00000100_9E_89, CMD_OTHER, OPND_ENC_MODREGRM_RM_REG, 7'b0000010,
          1, 32'h3100, 32'hDEAD, 0, 32'h3100, 32'hBEEF0002,
          5, 32'hBEEF0002, 32'h1000, 0, DEST_MEM, 0, DEST_NONE, 0);
  add_vec(88'h03_F7, CMD_OTHER, OPND_ENC_MODREGRM_RM, 7'b0000010,
          0, 32'h2000, 32'h77, 0, 32'h2004, 32'h78,
          1, 0, 0, 0, DEST_MEM, 0, DEST_NONE, 0);
  // Addressing edge cases
  add_vec(88'h00000004_D5_8C_8D, CMD_LEA, OPND_ENC_MODREGRM_REG_RM, 7'b0000010,
          0, 0, 0, 0, 0, 0, 6, 32'h10, 32'h2104, 0, DEST_REG, 1, DEST_NONE, 0);
  add_vec(88'h00005000_3D_8B, CMD_OTHER, OPND_ENC_MODREGRM_REG_RM, 7'b0000010,
          0, 32'h5000, 32'h55550011, 0, 32'h5000, 32'h99990011,
          5, 32'h4000, 32'h55550011, 0, DEST_REG, 7, DEST_NONE, 0);
  add_vec(88'h00006000_25_14_8B, CMD_OTHER, OPND_ENC_MODREGRM_REG_RM, 7'b0000010,
          0, 32'h6004, 32'h1, 0, 32'h6000, 32'h66660012,
          6, 32'h20, 32'h66660012, 0, DEST_REG, 2, DEST_NONE, 0);
  // String commands, EDI holds A0 and ESI holds B0
  add_vec(88'hA5, CMD_MOVS, OPND_ENC_NONE, 7'b0000010, 0, 32'h4000, 32'hA0, 0, 32'h3000, 32'hB0,
          0, 32'hA0, 32'hB0, 0, DEST_MEM, 0, DEST_NONE, 0);
  add_vec(88'hA7, CMD_CMPS, OPND_ENC_NONE, 7'b0000000, 0, 32'h4000, 32'hA0, 0, 32'h3000, 32'hB0,
          0, 32'hB0, 32'hA0, 0, DEST_NONE, 0, DEST_NONE, 0);
  add_vec(88'hAB, CMD_STOS, OPND_ENC_NONE, 7'b0000010, 0, 32'h4000, 32'hA0, 0, 32'h3000, 32'hB0,
          0, 32'hA0, 0, 0, DEST_MEM, 0, DEST_NONE, 0);
  add_vec(88'hAD, CMD_LODS, OPND_ENC_NONE, 7'b0000000, 0, 32'h4000, 32'hA0, 0, 32'h3000, 32'hB0,
          0, 0, 32'hB0, 0, DEST_NONE, 0, DEST_NONE, 0);
  add_vec(88'hAF, CMD_SCAS, OPND_ENC_NONE, 7'b0000000, 0, 32'h4000, 32'hA0, 0, 32'h3000, 32'hB0,
          0, 32'hA0, 0, 0, DEST_NONE, 0, DEST_NONE, 0);
  // Immediates, displacements, phonies and CALL
  add_vec(88'h80_B9, CMD_OTHER, OPND_ENC_REG_IMM, 7'b1100010, 0, 0, 0, 0, 0, 0,
          1, 32'h10, 32'hFFFFFF80, 0, DEST_REG, 1, DEST_NONE, 0);
  add_vec(88'h90_C2_83, CMD_OTHER, OPND_ENC_MODREGRM_RM_IMM, 7'b1000010, 0, 0, 0, 0, 0, 0,
          2, 32'h20, 32'h90, 0, DEST_REG, 2, DEST_NONE, 0);
  add_vec(88'hFE_6A, CMD_OTHER, OPND_ENC_IMM, 7'b1100000, 0, 0, 0, 0, 0, 0,
          1, 32'hFFFFFFFE, 0, 0, DEST_NONE, 0, DEST_NONE, 0);
  // Constant one beats the immediate on operand 0
  add_vec(88'h05_6A, CMD_OTHER, OPND_ENC_IMM, 7'b1110000, 0, 0, 0, 0, 0, 0,
          1, 1, 0, 0, DEST_NONE, 0, DEST_NONE, 0);
  add_vec(88'hF0_EB, CMD_OTHER, OPND_ENC_DISP8, 7'b0000000, 0, 0, 0, 0, 0, 0,
          1, 32'hFFFFFFF0, 0, 0, DEST_NONE, 0, DEST_NONE, 0);
  add_vec(88'h00000010_E8, CMD_CALLI, OPND_ENC_DISP32, 7'b0000000, 0, 0, 0, 0, 0, 0,
          4, 32'h10, 32'h8000, 32'h4, DEST_NONE, 0, DEST_NONE, 0);
endtask

`endif

/* dv/opnd_decode_tb.sv */
`include "x86_opnd_defines.svh"

module opnd_decode_tb;
  import x86_opnd_pkg::*;

  localparam int PERIOD = 40;
  localparam int MAX_VEC = 32;

  logic clk, rst, in_valid, in_ready, out_valid, out_ready;
  logic [`INSTR_W-1:0] instr;
  cmd_e opc;
  opnd_form_e opnd_form;
  logic imm_1byte, source_is_sext, opnd0_is_one, opnd1_is_one, opnd2_is_one;
  logic opnd0_is_write, opnd1_is_write, hint1_is_write, hint2_is_write;
  logic [31:0] eax, ecx, edx, ebx, esp, ebp, esi, edi;
  logic [31:0] hint1_address, hint1_data, hint2_address, hint2_data;
  logic [3:0] instr_body_len;
  logic [31:0] opnd0, opnd1, opnd2;
  dest_kind_e dest0_kind, dest1_kind;
  logic [2:0] dest0_sel, dest1_sel;

  // Stimulus and expected table
  logic [`INSTR_W-1:0] v_instr [MAX_VEC];
  cmd_e v_opc [MAX_VEC];
  opnd_form_e v_form [MAX_VEC];
  logic [6:0] v_flags [MAX_VEC];
  // Both hints, {wr, addr, data} each
  logic [129:0] v_hints [MAX_VEC];
  logic [3:0] v_len [MAX_VEC];
  logic [31:0] v_op0 [MAX_VEC], v_op1 [MAX_VEC], v_op2 [MAX_VEC];
  logic [9:0] v_dest [MAX_VEC];
  int n_vec = 0;
  bit loaded = 0;
  int errors = 0;
  int checks = 0;
  int out_idx = 0;
  int seed_val;

  // Snapshot of a stalled result
  bit held = 0;
  logic [31:0] h_op0, h_op1, h_op2;
  logic [13:0] h_misc;

  clk_gen #(.PERIOD(PERIOD)) u_clk (.clk(clk));

  opnd_decode_stage DUT (.*);

  task automatic add_vec(input logic [`INSTR_W-1:0] i_bytes, input cmd_e c, input opnd_form_e f,
                         input logic [6:0] flags, input logic h1w, input logic [31:0] h1a,
                         input logic [31:0] h1d, input logic h2w, input logic [31:0] h2a,
                         input logic [31:0] h2d, input logic [3:0] len,
                         input logic [31:0] e0, input logic [31:0] e1, input logic [31:0] e2,
                         input dest_kind_e k0, input logic [2:0] s0,
                         input dest_kind_e k1, input logic [2:0] s1);
    v_instr[n_vec] = i_bytes;
    v_opc[n_vec] = c;
    v_form[n_vec] = f;
    v_flags[n_vec] = flags;
    v_hints[n_vec] = {h1w, h1a, h1d, h2w, h2a, h2d};
    v_len[n_vec] = len;
    v_op0[n_vec] = e0;
    v_op1[n_vec] = e1;
    v_op2[n_vec] = e2;
    v_dest[n_vec] = {k0, s0, k1, s1};
    n_vec++;
  endtask

  `include "opnd_vectors.svh"

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic apply_vec(input int k);
    instr = v_instr[k];
    opc = v_opc[k];
    opnd_form = v_form[k];
    {imm_1byte, source_is_sext, opnd0_is_one, opnd1_is_one, opnd2_is_one,
     opnd0_is_write, opnd1_is_write} = v_flags[k];
    {hint1_is_write, hint1_address, hint1_data,
     hint2_is_write, hint2_address, hint2_data} = v_hints[k];
    in_valid = 1'b1;
  endtask

  // Driver, inputs change on the falling edge and hold until accepted
  initial begin
    int idx;
    rst = 1'b1;
    in_valid = 1'b0;
    out_ready = 1'b0;
    instr = '0;
    opc = CMD_OTHER;
    opnd_form = OPND_ENC_NONE;
    {imm_1byte, source_is_sext, opnd0_is_one, opnd1_is_one, opnd2_is_one} = '0;
    {opnd0_is_write, opnd1_is_write, hint1_is_write, hint2_is_write} = '0;
    {hint1_address, hint1_data, hint2_address, hint2_data} = '0;
    eax = 32'h100;
    ecx = 32'h10;
    edx = 32'h20;
    ebx = 32'h1000;
    esp = 32'h8000;
    ebp = 32'h2000;
    esi = 32'h3000;
    edi = 32'h4000;
    load_vectors();
    loaded = 1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("out_valid", 0, out_valid);
    idx = 0;
    while (idx < n_vec) begin
      apply_vec(idx);
      // Mid low phase, handshake inputs are settled
      #(PERIOD / 4);
      if (in_ready) idx++;
      @(negedge clk);
    end
    in_valid = 1'b0;
  end

  // Monitor with random back-pressure, about 30 percent busy
  initial begin
    seed_val = $urandom(32'h4a21);
    @(negedge rst);
    forever begin
      @(negedge clk);
      out_ready = ($urandom % 100) >= 30;
      #(PERIOD / 4);
      if (held) begin
        check_value("held opnd0", h_op0, opnd0);
        check_value("held opnd1", h_op1, opnd1);
        check_value("held opnd2", h_op2, opnd2);
        check_value("held misc", h_misc,
                    {instr_body_len, dest0_kind, dest0_sel, dest1_kind, dest1_sel});
      end
      if (out_valid && out_ready && out_idx < n_vec) begin
        check_value("instr_body_len", v_len[out_idx], instr_body_len);
        check_value("opnd0", v_op0[out_idx], opnd0);
        check_value("opnd1", v_op1[out_idx], opnd1);
        check_value("opnd2", v_op2[out_idx], opnd2);
        check_value("dest0_kind", v_dest[out_idx][9:8], dest0_kind);
        check_value("dest0_sel", v_dest[out_idx][7:5], dest0_sel);
        check_value("dest1_kind", v_dest[out_idx][4:3], dest1_kind);
        check_value("dest1_sel", v_dest[out_idx][2:0], dest1_sel);
        out_idx++;
      end
      held = out_valid && !out_ready;
      h_op0 = opnd0;
      h_op1 = opnd1;
      h_op2 = opnd2;
      h_misc = {instr_body_len, dest0_kind, dest0_sel, dest1_kind, dest1_sel};
    end
  end

  // End of run once every entry has come out
  initial begin
    wait (loaded);
    wait (out_idx == n_vec);
    repeat (3) @(negedge clk);
    // An extra output after the last entry would be a duplicate
    if (out_valid) begin
      errors++;
      $display("Unexpected extra result after the last table entry");
    end
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (loaded);
    #(n_vec * 20 * PERIOD);
    $display("Timeout, only %0d of %0d results came out", out_idx, n_vec);
    $display("%0d errors in %0d checks", errors, checks);
    $display("Testbench failed");
    $finish;
  end
endmodule

/* dv/clk_gen.sv */
module clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  // Free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end
endmodule

/* hw/opnd_decode_stage.sv */
`include "x86_opnd_defines.svh"

module opnd_decode_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [`INSTR_W-1:0]      instr,
  input  x86_opnd_pkg::cmd_e       opc,
  input  x86_opnd_pkg::opnd_form_e opnd_form,
  input  logic                     imm_1byte,
  input  logic                     source_is_sext,
  input  logic                     opnd0_is_one,
  input  logic                     opnd1_is_one,
  input  logic                     opnd2_is_one,
  input  logic                     opnd0_is_write,
  input  logic                     opnd1_is_write,
  input  logic [`WORD_W-1:0]       eax, ecx, edx, ebx, esp, ebp, esi, edi,
  input  logic                     hint1_is_write,
  input  logic                     hint2_is_write,
  input  logic [`WORD_W-1:0]       hint1_address,
  input  logic [`WORD_W-1:0]       hint1_data,
  input  logic [`WORD_W-1:0]       hint2_address,
  input  logic [`WORD_W-1:0]       hint2_data,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [`LEN_W-1:0]        instr_body_len,
  output logic [`WORD_W-1:0]       opnd0, opnd1, opnd2,
  output x86_opnd_pkg::dest_kind_e dest0_kind,
  output x86_opnd_pkg::dest_kind_e dest1_kind,
  output logic [`REGSEL_W-1:0]     dest0_sel,
  output logic [`REGSEL_W-1:0]     dest1_sel
);
  import x86_opnd_pkg::*;

  gpr_file_t            gprs;
  logic [`WORD_W-1:0]   d_opnd0, d_opnd1, d_opnd2;
  dest_kind_e           d_dest0_kind, d_dest1_kind;
  logic [`REGSEL_W-1:0] d_dest0_sel, d_dest1_sel;

  opnd_fields_if fields_if ();
  mem_hint_if    hint_if ();

  // Register file in x86 index order
  assign gprs[`REG_EAX] = eax;
  assign gprs[`REG_ECX] = ecx;
  assign gprs[`REG_EDX] = edx;
  assign gprs[`REG_EBX] = ebx;
  assign gprs[`REG_ESP] = esp;
  assign gprs[`REG_EBP] = ebp;
  assign gprs[`REG_ESI] = esi;
  assign gprs[`REG_EDI] = edi;

  assign hint_if.hint1_is_write = hint1_is_write;
  assign hint_if.hint1_address  = hint1_address;
  assign hint_if.hint1_data     = hint1_data;
  assign hint_if.hint2_is_write = hint2_is_write;
  assign hint_if.hint2_address  = hint2_address;
  assign hint_if.hint2_data     = hint2_data;

  opnd_fields u_fields (
    .instr          (instr),
    .opnd_form      (opnd_form),
    .imm_1byte      (imm_1byte),
    .source_is_sext (source_is_sext),
    .fields         (fields_if.producer)
  );

  decode_opnds u_decode (
    .opc (opc), .opnd_form (opnd_form), .opcode_byte (instr[7:0]), .gprs (gprs),
    .opnd0_is_one (opnd0_is_one), .opnd1_is_one (opnd1_is_one),
    .opnd2_is_one (opnd2_is_one), .opnd0_is_write (opnd0_is_write),
    .opnd1_is_write (opnd1_is_write),
    .fields (fields_if.consumer), .hints (hint_if.reader),
    .opnd0 (d_opnd0), .opnd1 (d_opnd1), .opnd2 (d_opnd2),
    .dest0_kind (d_dest0_kind), .dest1_kind (d_dest1_kind),
    .dest0_sel (d_dest0_sel), .dest1_sel (d_dest1_sel)
  );

  // Output slot frees up when empty or draining
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Result payload, loaded only on acceptance
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      instr_body_len <= fields_if.body_len;
      opnd0          <= d_opnd0;
      opnd1          <= d_opnd1;
      opnd2          <= d_opnd2;
      dest0_kind     <= d_dest0_kind;
      dest1_kind     <= d_dest1_kind;
      dest0_sel      <= d_dest0_sel;
      dest1_sel      <= d_dest1_sel;
    end
  end

  // Stalled result must hold until taken
  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid &&
      $stable({instr_body_len, opnd0, opnd1, opnd2, dest0_kind, dest1_kind,
               dest0_sel, dest1_sel}))
    else $error("output changed while stalled");
endmodule

/* hw/decode_opnds.sv */
`include "x86_opnd_defines.svh"

module decode_opnds (
  input  x86_opnd_pkg::cmd_e       opc,
  input  x86_opnd_pkg::opnd_form_e opnd_form,
  input  logic [7:0]               opcode_byte,
  input  x86_opnd_pkg::gpr_file_t  gprs,
  input  logic                     opnd0_is_one,
  input  logic                     opnd1_is_one,
  input  logic                     opnd2_is_one,
  input  logic                     opnd0_is_write,
  input  logic                     opnd1_is_write,
  opnd_fields_if.consumer          fields,
  mem_hint_if.reader               hints,
  output logic [`WORD_W-1:0]       opnd0,
  output logic [`WORD_W-1:0]       opnd1,
  output logic [`WORD_W-1:0]       opnd2,
  output x86_opnd_pkg::dest_kind_e dest0_kind,
  output x86_opnd_pkg::dest_kind_e dest1_kind,
  output logic [`REGSEL_W-1:0]     dest0_sel,
  output logic [`REGSEL_W-1:0]     dest1_sel
);
  import x86_opnd_pkg::*;

  logic                 rm_is_mem;
  logic                 str0_edi, str0_esi, str1_esi, str1_edi;
  logic                 opnd0_is_reg, opnd1_is_reg, opnd0_is_mem, opnd1_is_mem;
  logic [`REGSEL_W-1:0] opnd0_regsel, opnd1_regsel;
  logic [`REGSEL_W-1:0] mem_base_sel, opnd0_base_sel, opnd1_base_sel;
  logic                 mem_use_base, mem_use_index;
  logic [`WORD_W-1:0]   opnd0_disp, opnd1_disp;
  logic [`WORD_W-1:0]   opnd0_addr, opnd1_addr, opnd0_mval, opnd1_mval;
  logic [`WORD_W-1:0]   opnd0_memval, opnd1_memval;
  logic                 call_phony;

  // Register operands
  assign opnd0_is_reg = opnd_form inside {OPND_ENC_REG, OPND_ENC_REG_IMM,
                                          OPND_ENC_EAX_IMM, OPND_ENC_EAX_REG} ||
                        (fields.opnd0_modrm_rm && fields.rm_is_reg_direct) ||
                        fields.opnd0_modrm_reg;
  assign opnd1_is_reg = opnd_form == OPND_ENC_EAX_REG ||
                        (fields.opnd1_modrm_rm && fields.rm_is_reg_direct) ||
                        fields.opnd1_modrm_reg;

  // Selector sources: opcode low bits, rm direct, reg, implicit EAX
  assign opnd0_regsel =
    (opnd_form inside {OPND_ENC_REG, OPND_ENC_REG_IMM}) ? opcode_byte[2:0] :
    (fields.opnd0_modrm_rm && fields.rm_is_reg_direct)  ? fields.modrm[2:0] :
    fields.opnd0_modrm_reg                              ? fields.modrm[5:3] :
    (opnd_form inside {OPND_ENC_EAX_IMM, OPND_ENC_EAX_REG}) ? `REG_EAX : '0;
  assign opnd1_regsel =
    (fields.opnd1_modrm_rm && fields.rm_is_reg_direct) ? fields.modrm[2:0] :
    fields.opnd1_modrm_reg                             ? fields.modrm[5:3] :
    (opnd_form == OPND_ENC_EAX_REG)                    ? opcode_byte[2:0] : '0;

  // String commands address memory through implicit ESI/EDI
  assign str0_edi = opc inside {CMD_MOVS, CMD_STOS, CMD_SCAS};
  assign str0_esi = opc == CMD_CMPS;
  assign str1_esi = opc inside {CMD_MOVS, CMD_LODS};
  assign str1_edi = opc == CMD_CMPS;

  assign rm_is_mem    = fields.has_modrm && !fields.rm_is_reg_direct;
  assign opnd0_is_mem = str0_edi || str0_esi || (fields.opnd0_modrm_rm && rm_is_mem);
  assign opnd1_is_mem = str1_esi || str1_edi || (fields.opnd1_modrm_rm && rm_is_mem);

  // Explicit addressing: SIB base, else rm
  assign mem_base_sel  = fields.has_sib ? fields.sib[2:0] : fields.modrm[2:0];
  // mod 00 with rm 101, or SIB base 101, means disp32 with no base
  assign mem_use_base  = !(fields.modrm[7:6] == 2'b00 &&
                           ((!fields.has_sib && fields.modrm[2:0] == 3'b101) ||
                            (fields.has_sib && fields.sib[2:0] == 3'b101)));
  assign mem_use_index = fields.has_sib && fields.sib[5:3] != 3'b100;

  assign opnd0_base_sel = str0_edi ? `REG_EDI : str0_esi ? `REG_ESI : mem_base_sel;
  assign opnd1_base_sel = str1_esi ? `REG_ESI : str1_edi ? `REG_EDI : mem_base_sel;
  assign opnd0_disp = (fields.opnd0_disp && !(str0_edi || str0_esi)) ? fields.disp : '0;
  assign opnd1_disp = (fields.opnd1_disp && !(str1_esi || str1_edi)) ? fields.disp : '0;

  mem_opnd_fetch u_fetch0 (
    .gprs      (gprs),
    .base_sel  (opnd0_base_sel),
    .index_sel (fields.sib[5:3]),
    .use_base  (str0_edi || str0_esi || mem_use_base),
    .use_index (!(str0_edi || str0_esi) && mem_use_index),
    .scale     (fields.sib[7:6]),
    .disp      (opnd0_disp),
    .hints     (hints),
    .address   (opnd0_addr),
    .mem_value (opnd0_mval)
  );

  mem_opnd_fetch u_fetch1 (
    .gprs      (gprs),
    .base_sel  (opnd1_base_sel),
    .index_sel (fields.sib[5:3]),
    .use_base  (str1_esi || str1_edi || mem_use_base),
    .use_index (!(str1_esi || str1_edi) && mem_use_index),
    .scale     (fields.sib[7:6]),
    .disp      (opnd1_disp),
    .hints     (hints),
    .address   (opnd1_addr),
    .mem_value (opnd1_mval)
  );

  // LEA takes the address itself, no memory read
  assign opnd0_memval = (opc == CMD_LEA) ? opnd0_addr : opnd0_mval;
  assign opnd1_memval = (opc == CMD_LEA) ? opnd1_addr : opnd1_mval;

  // CALL reuses the ALU for ESP - 4
  assign call_phony = opc inside {CMD_CALLR, CMD_CALLI};

  // Priority phony, reg, mem, imm, disp
  assign opnd0 = opnd0_is_one ? 32'd1 :
                 opnd0_is_reg ? gprs[opnd0_regsel] :
                 opnd0_is_mem ? opnd0_memval :
                 (opnd_form == OPND_ENC_IMM) ? fields.imm :
                 (opnd_form inside {OPND_ENC_DISP8, OPND_ENC_DISP32}) ? fields.disp : '0;
  assign opnd1 = opnd1_is_one ? 32'd1 :
                 call_phony   ? gprs[`REG_ESP] :
                 opnd1_is_reg ? gprs[opnd1_regsel] :
                 opnd1_is_mem ? opnd1_memval :
                 (opnd_form inside {OPND_ENC_MODREGRM_RM_IMM, OPND_ENC_REG_IMM,
                                    OPND_ENC_EAX_IMM}) ? fields.imm : '0;
  assign opnd2 = opnd2_is_one ? 32'd1 : call_phony ? 32'd4 : '0;

  // Writeback targets only for written operands
  assign dest0_kind = !opnd0_is_write ? DEST_NONE :
                      opnd0_is_reg ? DEST_REG : opnd0_is_mem ? DEST_MEM : DEST_NONE;
  assign dest1_kind = !opnd1_is_write ? DEST_NONE :
                      opnd1_is_reg ? DEST_REG : opnd1_is_mem ? DEST_MEM : DEST_NONE;
  assign dest0_sel  = (dest0_kind == DEST_REG) ? opnd0_regsel : '0;
  assign dest1_sel  = (dest1_kind == DEST_REG) ? opnd1_regsel : '0;

  // Register and memory classifications come from separate decode paths
  always_comb begin
    assert final (!(opnd0_is_reg && opnd0_is_mem) && !(opnd1_is_reg && opnd1_is_mem))
      else $error("operand classified as both register and memory");
  end
endmodule

/* hw/mem_opnd_fetch.sv */
`include "x86_opnd_defines.svh"

module mem_opnd_fetch (
  input  x86_opnd_pkg::gpr_file_t gprs,
  input  logic [`REGSEL_W-1:0]    base_sel,
  input  logic [`REGSEL_W-1:0]    index_sel,
  input  logic                    use_base,
  input  logic                    use_index,
  input  logic [1:0]              scale,
  input  logic [`WORD_W-1:0]      disp,
  mem_hint_if.reader              hints,
  output logic [`WORD_W-1:0]      address,
  output logic [`WORD_W-1:0]      mem_value
);

  logic [`WORD_W-1:0] base_val;
  logic [`WORD_W-1:0] index_val;
  logic               hint1_hit;
  logic               hint2_hit;

  // Missing base or index contributes nothing
  assign base_val  = use_base ? gprs[base_sel] : '0;
  assign index_val = use_index ? (gprs[index_sel] << scale) : '0;

  // Effective address, wraps at 32 bits
  assign address = base_val + index_val + disp;

  // Only read hints stand for memory contents
  assign hint1_hit = !hints.hint1_is_write && hints.hint1_address == address;
  assign hint2_hit = !hints.hint2_is_write && hints.hint2_address == address;

  // hint1 wins when both match
  always_comb begin
    if (hint1_hit) begin
      mem_value = hints.hint1_data;
    end else if (hint2_hit) begin
      mem_value = hints.hint2_data;
    end else begin
      mem_value = '0;
    end
  end
endmodule

/* hw/opnd_fields.sv */
`include "x86_opnd_defines.svh"

module opnd_fields (
  input  logic [`INSTR_W-1:0]     instr,
  input  x86_opnd_pkg::opnd_form_e opnd_form,
  input  logic                    imm_1byte,
  input  logic                    source_is_sext,
  opnd_fields_if.producer         fields
);
  import x86_opnd_pkg::*;

  logic [1:0]          mod;
  logic [2:0]          rm;
  logic                has_modrm;
  logic                has_sib;
  logic                has_imm;
  logic [`LEN_W-1:0]   disp_len;
  logic [`LEN_W-1:0]   imm_len;
  logic [`LEN_W-1:0]   disp_pos;
  logic [`LEN_W-1:0]   imm_pos;
  logic [`INSTR_W-1:0] disp_bytes;
  logic [`INSTR_W-1:0] imm_bytes;

  // ModR/M always sits in byte 1, SIB in byte 2
  assign has_modrm = opnd_form inside {OPND_ENC_MODREGRM_RM, OPND_ENC_MODREGRM_RM_REG,
                                       OPND_ENC_MODREGRM_REG_RM, OPND_ENC_MODREGRM_RM_IMM};
  assign mod       = instr[15:14];
  assign rm        = instr[10:8];
  assign has_sib   = has_modrm && mod != 2'b11 && rm == 3'b100;
  assign has_imm   = opnd_form inside {OPND_ENC_IMM, OPND_ENC_MODREGRM_RM_IMM,
                                       OPND_ENC_EAX_IMM, OPND_ENC_REG_IMM};

  // Displacement size, from ModR/M or from the bare DISP forms
  always_comb begin
    disp_len = '0;
    if (opnd_form == OPND_ENC_DISP8) begin
      disp_len = 4'd1;
    end else if (opnd_form == OPND_ENC_DISP32) begin
      disp_len = 4'd4;
    end else if (has_modrm) begin
      if (mod == 2'b01) begin
        disp_len = 4'd1;
      end else if (mod == 2'b10) begin
        disp_len = 4'd4;
      end else if (mod == 2'b00 && !has_sib && rm == 3'b101) begin
        // Absolute disp32, no base
        disp_len = 4'd4;
      end else if (mod == 2'b00 && has_sib && instr[18:16] == 3'b101) begin
        disp_len = 4'd4;
      end
    end
  end

  assign imm_len  = !has_imm ? 4'd0 : (imm_1byte ? 4'd1 : 4'd4);

  // Field positions follow the opcode byte in order
  assign disp_pos = 4'd1 + {3'b0, has_modrm} + {3'b0, has_sib};
  assign imm_pos  = disp_pos + disp_len;

  assign disp_bytes = instr >> {disp_pos, 3'b000};
  assign imm_bytes  = instr >> {imm_pos, 3'b000};

  assign fields.modrm     = instr[15:8];
  assign fields.sib       = instr[23:16];
  assign fields.has_modrm = has_modrm;
  assign fields.has_sib   = has_sib;
  assign fields.rm_is_reg_direct = has_modrm && mod == 2'b11;

  // disp8 is always sign-extended
  assign fields.disp = (disp_len == 4'd1) ? {{24{disp_bytes[7]}}, disp_bytes[7:0]} :
                       (disp_len == 4'd4) ? disp_bytes[31:0] : '0;

  assign fields.imm = !has_imm   ? '0 :
                      !imm_1byte ? imm_bytes[31:0] :
                      source_is_sext ? {{24{imm_bytes[7]}}, imm_bytes[7:0]} :
                                       {24'b0, imm_bytes[7:0]};

  // Operand positions by form
  assign fields.opnd0_modrm_rm  = opnd_form inside {OPND_ENC_MODREGRM_RM,
                                                    OPND_ENC_MODREGRM_RM_REG,
                                                    OPND_ENC_MODREGRM_RM_IMM};
  assign fields.opnd0_modrm_reg = opnd_form == OPND_ENC_MODREGRM_REG_RM;
  assign fields.opnd1_modrm_rm  = opnd_form == OPND_ENC_MODREGRM_REG_RM;
  assign fields.opnd1_modrm_reg = opnd_form == OPND_ENC_MODREGRM_RM_REG;
  // The ModR/M displacement belongs to whichever operand holds r/m
  assign fields.opnd0_disp = fields.opnd0_modrm_rm;
  assign fields.opnd1_disp = fields.opnd1_modrm_rm;

  assign fields.body_len = {3'b0, has_modrm} + {3'b0, has_sib} + disp_len + imm_len;

  // ModR/M + SIB + disp32 + imm32 at most
  always_comb begin
    assert final (fields.body_len <= 4'd10)
      else $error("body length %0d over 10 bytes", fields.body_len);
  end
endmodule

/* hw/mem_hint_if.sv */
`include "x86_opnd_defines.svh"

// Two address/data pairs standing in for memory
interface mem_hint_if;
  logic               hint1_is_write;
  logic [`WORD_W-1:0] hint1_address;
  logic [`WORD_W-1:0] hint1_data;
  logic               hint2_is_write;
  logic [`WORD_W-1:0] hint2_address;
  logic [`WORD_W-1:0] hint2_data;

  modport source (
    output hint1_is_write, hint1_address, hint1_data,
    output hint2_is_write, hint2_address, hint2_data
  );

  modport reader (
    input hint1_is_write, hint1_address, hint1_data,
    input hint2_is_write, hint2_address, hint2_data
  );
endinterface

/* hw/opnd_fields_if.sv */
`include "x86_opnd_defines.svh"

// Extracted instruction fields, parser to operand selector
interface opnd_fields_if;
  logic [7:0]         modrm;
  logic [7:0]         sib;
  // Sign-extended displacement
  logic [`WORD_W-1:0] disp;
  // Sign- or zero-extended immediate
  logic [`WORD_W-1:0] imm;
  logic               has_modrm;
  logic               has_sib;
  logic               rm_is_reg_direct;
  // Which operand takes ModR/M rm, reg and the displacement
  logic               opnd0_modrm_rm;
  logic               opnd0_modrm_reg;
  logic               opnd0_disp;
  logic               opnd1_modrm_rm;
  logic               opnd1_modrm_reg;
  logic               opnd1_disp;
  logic [`LEN_W-1:0]  body_len;

  modport producer (
    output modrm, sib, disp, imm, has_modrm, has_sib, rm_is_reg_direct,
    output opnd0_modrm_rm, opnd0_modrm_reg, opnd0_disp,
    output opnd1_modrm_rm, opnd1_modrm_reg, opnd1_disp, body_len
  );

  modport consumer (
    input modrm, sib, disp, imm, has_modrm, has_sib, rm_is_reg_direct,
    input opnd0_modrm_rm, opnd0_modrm_reg, opnd0_disp,
    input opnd1_modrm_rm, opnd1_modrm_reg, opnd1_disp
  );
endinterface

/* hw/x86_opnd_pkg.sv */
`include "x86_opnd_defines.svh"

package x86_opnd_pkg;

  // Command codes the operand stage cares about
  typedef enum logic [6:0] {
    CMD_OTHER = 7'd0,
    CMD_LEA   = 7'd1,
    CMD_MOVS  = 7'd2,
    CMD_CMPS  = 7'd3,
    CMD_SCAS  = 7'd4,
    CMD_STOS  = 7'd5,
    CMD_LODS  = 7'd6,
    CMD_CALLR = 7'd7,
    CMD_CALLI = 7'd8
  } cmd_e;

  // Operand encoding forms
  typedef enum logic [3:0] {
    OPND_ENC_NONE            = 4'd0,
    OPND_ENC_IMM             = 4'd1,
    // Register index in opcode bits 2:0
    OPND_ENC_REG             = 4'd2,
    OPND_ENC_MODREGRM_RM     = 4'd3,
    OPND_ENC_MODREGRM_RM_REG = 4'd4,
    OPND_ENC_MODREGRM_REG_RM = 4'd5,
    OPND_ENC_MODREGRM_RM_IMM = 4'd6,
    OPND_ENC_EAX_IMM         = 4'd7,
    OPND_ENC_EAX_REG         = 4'd8,
    OPND_ENC_REG_IMM         = 4'd9,
    OPND_ENC_DISP8           = 4'd10,
    OPND_ENC_DISP32          = 4'd11
  } opnd_form_e;

  // Where a written operand goes
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_kind_e;

  // Eight general registers, indexed by register selector
  typedef logic [7:0][`WORD_W-1:0] gpr_file_t;

endpackage

/* hw/x86_opnd_defines.svh */
`ifndef X86_OPND_DEFINES_SVH
`define X86_OPND_DEFINES_SVH

// Raw instruction bytes, prefixes already stripped
`define INSTR_W 88

// Width of one operand or general register
`define WORD_W 32

// Instruction body length field, counts up to 10 bytes
`define LEN_W 4

// Width of a register selector
`define REGSEL_W 3

// General register indices in x86 encoding order
`define REG_EAX 3'd0
`define REG_ECX 3'd1
`define REG_EDX 3'd2
`define REG_EBX 3'd3
`define REG_ESP 3'd4
`define REG_EBP 3'd5
`define REG_ESI 3'd6
`define REG_EDI 3'd7

`endif
